// ==== all.f ====
+incdir+common
common/busPkg.sv
common/combinerPkg.sv
hdl/busDecoder.sv
combiner/combinerRegs.sv
combiner/combinerSweep.sv
hdl/combinerTop.sv
dv/combinerChecker.sv
dv/tbTop.sv

// ==== run.sh ====
#!/bin/bash
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tbTop -f all.f -o simTb \
    && ./obj_dir/simTb 2>&1 | tee sim.log \
    || { echo "build or simulation error"; exit 1; }

grep -q "TB FAILED" sim.log && { echo "simulation reported failure"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

// ==== dv/tbTop.sv ====
// Combiner testbench top
`timescale 1ns/1ps
`include "combiner_defines.svh"

module tbTop import busPkg::*; ();

    logic              busClk;
    logic              rstN;
    regBusReq_t        busReq;
    regBusRsp_t        busRsp;
    logic [`AGC_W-1:0] agc0;
    logic [`AGC_W-1:0] agc1;
    logic              realLock;
    logic              imagLock;
    logic              locked;
    logic              ddsMiso;
    logic [7:0]        index;
    logic [7:0]        addr;
    logic [5:0]        off;
    int                checkCount;
    int                errCount;
    int                testChecks;
    int                testErrors;
    int                testCount = 0;
    bit                timedOut = 1'b0;
    int unsigned       seedDraw;

    combinerTop uut (.busClk(busClk), .rstN(rstN), .busReq(busReq), .busRsp(busRsp),
                     .agc0(agc0), .agc1(agc1), .realLock(realLock), .imagLock(imagLock),
                     .locked(locked), .ddsMiso(ddsMiso), .index(index));

    combinerChecker compareUnit (.busClk(busClk), .rstN(rstN), .busReq(busReq),
                                 .busRsp(busRsp), .agc0(agc0), .agc1(agc1),
                                 .realLock(realLock), .imagLock(imagLock), .locked(locked),
                                 .ddsMiso(ddsMiso), .index(index), .checkCount(checkCount),
                                 .errCount(errCount));

    always #10 busClk = ~busClk;

    // One request per cycle, applied just after the rising edge.
    task automatic driveBus(input logic [7:0] a, input logic [31:0] data,
                            input logic [3:0] lanes, input logic sel);
        @(posedge busClk);
        #2;
        busReq.addr   = a;
        busReq.wrData = data;
        busReq.byteWr = lanes;
        busReq.sel    = sel;
    endtask

    task automatic readReg(input logic [5:0] o);
        driveBus({`COMB_BASE, o}, $urandom, 4'h0, 1'b1);  // write data is noise on a read.
    endtask

    task automatic writeReg(input logic [5:0] o, input logic [31:0] data, input logic [3:0] lanes);
        driveBus({`COMB_BASE, o}, data, lanes, 1'b1);
    endtask

    task automatic startTest();
        testChecks = checkCount;
        testErrors = errCount;
    endtask

    // Waits until the checker has compared the last driven cycle.
    task automatic finishTest(input string name);
        int target;
        target = checkCount + 2;
        for (int n = 0; n < 20 && checkCount < target; n++) begin
            @(posedge busClk);
        end
        #2;
        if (checkCount < target) begin
            timedOut = 1'b1;
            $display("Timeout: the checker stopped comparing during test %s", name);
        end
        testCount++;
        $display("test %s: %0d checks, %0d mismatches", name, checkCount - testChecks,
                 errCount - testErrors);
    endtask

    initial begin
        seedDraw = $urandom(32'h2e9a4063);
        busClk   = 1'b0;
        rstN     = 1'b0;
        busReq   = '0;
        agc0     = '0;
        agc1     = '0;
        realLock = 1'b0;
        imagLock = 1'b0;
        locked   = 1'b0;
        ddsMiso  = 1'b0;
        repeat (5) @(posedge busClk);
        #2;
        rstN = 1'b1;

        startTest();
        for (int r = 0; r < 6; r++) begin
            readReg(6'(r));
        end
        finishTest("reset state");

        startTest();
        for (int n = 0; n < 200; n++) begin
            off = 6'($urandom % 6);
            writeReg(off, $urandom, 4'($urandom));
            readReg(off);
        end
        finishTest("byte-lane writes");

        startTest();
        for (int n = 0; n < 150; n++) begin
            {realLock, imagLock, locked, ddsMiso} = 4'($urandom);
            agc0 = 16'($urandom);
            agc1 = 16'($urandom);
            addr = (n < 64) ? {`COMB_BASE, 6'(n)} : 8'($urandom);  // whole bank, then anywhere.
            driveBus(addr, $urandom, 4'h0, ($urandom % 4) != 0);
        end
        finishTest("mixed readback");

        startTest();
        locked = 1'b0;
        writeReg(`COMB_OPTIONS, 32'h0001_0000, 4'b1100);
        for (int round = 0; round < 3; round++) begin
            writeReg(`COMB_SWEEP_RATE, $urandom >> 5, 4'hf);  // small steps, several per wrap.
            writeReg(`COMB_SWEEP_LIMIT, $urandom, 4'b0011);
            for (int n = 0; n < 100; n++) begin
                if ($urandom % 12 == 0) begin
                    locked = !locked;
                end
                readReg((n % 2 == 0) ? `COMB_LAG_COEF : `COMB_LEAD_COEF);
            end
        end
        finishTest("sweep");

        startTest();
        for (int n = 0; n < 100; n++) begin
            agc0 = 16'($urandom);
            agc1 = ($urandom % 4 == 0) ? agc0 : 16'($urandom);
            readReg(`COMB_LAG_COEF);
        end
        finishTest("agc compare");

        $display("summary: %0d tests, %0d checks, %0d mismatches", testCount, checkCount,
                 errCount);
        if (errCount == 0 && !timedOut) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/combinerChecker.sv ====
// Combiner reference model and checker
`timescale 1ns/1ps
`include "combiner_defines.svh"

module combinerChecker import busPkg::*; import combinerPkg::*; (
    input  logic              busClk,
    input  logic              rstN,
    input  regBusReq_t        busReq,
    input  regBusRsp_t        busRsp,
    input  logic [`AGC_W-1:0] agc0,
    input  logic [`AGC_W-1:0] agc1,
    input  logic              realLock,
    input  logic              imagLock,
    input  logic              locked,
    input  logic              ddsMiso,
    input  logic [7:0]        index,
    output int                checkCount,
    output int                errCount
);

    logic [31:0] regM [6];  // the six words exactly as written, lane by lane.
    logic [31:0] accM;
    logic        flagM;
    logic        agcGtM;
    int          checks = 0;
    int          errors = 0;

    assign checkCount = checks;
    assign errCount   = errors;

    // The model steps on the same edge as the DUT, sweep first with the old settings.
    always @(posedge busClk) begin : modelStep
        logic [31:0] sum;
        int          off;
        sum = accM + regM[`COMB_SWEEP_RATE];
        off = int'(busReq.addr[`REG_ADDR_W-1:0]);
        if (!rstN) begin
            for (int r = 0; r < 6; r++) begin
                regM[r] <= '0;
            end
            accM   <= '0;
            flagM  <= 1'b0;
            agcGtM <= 1'b0;
        end else begin
            if (regM[`COMB_OPTIONS][16] && !locked) begin
                accM <= (sum[31:24] > regM[`COMB_SWEEP_LIMIT][7:0]) ? 32'h0 : sum;
            end
            flagM  <= regM[`COMB_OPTIONS][16] && !locked;
            agcGtM <= agc0 > agc1;
            if (busReq.sel && busReq.addr[`ADDR_W-1:`REG_ADDR_W] == `COMB_BASE && off < 6) begin
                for (int i = 0; i < 4; i++) begin
                    if (busReq.byteWr[i]) begin
                        regM[off][8*i +: 8] <= busReq.wrData[8*i +: 8];
                    end
                end
            end
        end
    end

    // Read words mask the stored lanes and mix in live status.
    function automatic logic [31:0] expectedRead(input regBusReq_t req, input combStat_t st);
        logic [31:0] word;
        word = '0;
        if (req.sel && req.addr[`ADDR_W-1:`REG_ADDR_W] == `COMB_BASE) begin
            case (req.addr[`REG_ADDR_W-1:0])
                `COMB_LAG_COEF:    word = {st.ddsMiso, st.realLock, st.imagLock, st.locked,
                                           st.combinerFlag, st.agc0GtAgc1, regM[0][25:0]};
                `COMB_LEAD_COEF:   word = {st.index, regM[1][23:0]};
                `COMB_SWEEP_RATE:  word = regM[2];
                `COMB_LOCKS:       word = regM[3];
                `COMB_SWEEP_LIMIT,
                `COMB_OPTIONS:     word = {regM[5][31:16], regM[4][15:0]};
                default:           word = '0;
            endcase
        end
        return word;
    endfunction

    task automatic compareWord(input string what, input logic [31:0] expWord,
                               input logic [31:0] gotWord);
        checks++;
        if (gotWord !== expWord) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, what, expWord, gotWord);
        end
    endtask

    // Outputs are settled mid-cycle, away from both drive and capture.
    always @(negedge busClk) begin : compareStep
        combStat_t expStat;
        expStat.index        = accM[31:24];
        expStat.combinerFlag = flagM;
        expStat.agc0GtAgc1   = agcGtM;
        expStat.realLock     = realLock;
        expStat.imagLock     = imagLock;
        expStat.locked       = locked;
        expStat.ddsMiso      = ddsMiso;
        if (rstN) begin
            compareWord("read data", expectedRead(busReq, expStat), busRsp.rdData);
            compareWord("index", {24'h0, expStat.index}, {24'h0, index});
        end
    end

endmodule

// ==== hdl/combinerTop.sv ====
// Combiner control and status top
`timescale 1ns/1ps
`include "combiner_defines.svh"

module combinerTop import busPkg::*; import combinerPkg::*; (
    input  logic              busClk,
    input  logic              rstN,
    input  regBusReq_t        busReq,
    output regBusRsp_t        busRsp,
    input  logic [`AGC_W-1:0] agc0,
    input  logic [`AGC_W-1:0] agc1,
    input  logic              realLock,
    input  logic              imagLock,
    input  logic              locked,
    input  logic              ddsMiso,
    output logic [7:0]        index
);

    logic                   cs;
    logic [`REG_ADDR_W-1:0] regAddr;
    logic [31:0]            bankData;
    combCfg_t               combCfg;
    combStat_t              combStat;

    busDecoder decoder (
        .busClk   (busClk),
        .rstN     (rstN),
        .busReq   (busReq),
        .busRsp   (busRsp),
        .cs       (cs),
        .regAddr  (regAddr),
        .bankData (bankData)
    );

    combinerRegs regs (
        .busClk   (busClk),
        .rstN     (rstN),
        .cs       (cs),
        .regAddr  (regAddr),
        .wrData   (busReq.wrData),
        .byteWr   (busReq.byteWr),
        .rdData   (bankData),
        .combStat (combStat),
        .combCfg  (combCfg)
    );

    combinerSweep sweep (
        .busClk   (busClk),
        .rstN     (rstN),
        .combCfg  (combCfg),
        .agc0     (agc0),
        .agc1     (agc1),
        .realLock (realLock),
        .imagLock (imagLock),
        .locked   (locked),
        .ddsMiso  (ddsMiso),
        .combStat (combStat)
    );

    assign index = combStat.index;  // phase index for the combining datapath.

endmodule

// ==== combiner/combinerSweep.sv ====
// Combiner phase sweep and AGC compare
`timescale 1ns/1ps
`include "combiner_defines.svh"

module combinerSweep import combinerPkg::*; (
    input  logic              busClk,
    input  logic              rstN,
    input  combCfg_t          combCfg,
    input  logic [`AGC_W-1:0] agc0,
    input  logic [`AGC_W-1:0] agc1,
    input  logic              realLock,
    input  logic              imagLock,
    input  logic              locked,
    input  logic              ddsMiso,
    output combStat_t         combStat
);

    logic [31:0] acc;
    logic [31:0] accSum;
    logic        sweeping;
    logic        combinerFlag;
    logic        agc0GtAgc1;

    assign sweeping = combCfg.sweepEnable && !locked;
    assign accSum   = acc + combCfg.sweepRate;  // wraps modulo 2^32.

    always_ff @(posedge busClk) begin
        if (!rstN) begin
            acc          <= '0;
            combinerFlag <= 1'b0;
            agc0GtAgc1   <= 1'b0;
        end else begin
            if (sweeping) begin
                if (accSum[31:24] > combCfg.sweepLimit) begin
                    acc <= '0;  // past the limit, restart from phase zero.
                end else begin
                    acc <= accSum;
                end
            end
            combinerFlag <= sweeping;
            agc0GtAgc1   <= agc0 > agc1;
        end
    end

    // Lock pins pass straight through to the status word.
    always_comb begin
        combStat.index        = acc[31:24];
        combStat.combinerFlag = combinerFlag;
        combStat.agc0GtAgc1   = agc0GtAgc1;
        combStat.realLock     = realLock;
        combStat.imagLock     = imagLock;
        combStat.locked       = locked;
        combStat.ddsMiso      = ddsMiso;
    end

    // Each sweep step lands at or below the limit it was taken against.
    assert property (@(posedge busClk) disable iff (!rstN)
        sweeping |=> combStat.index <= $past(combCfg.sweepLimit));

endmodule

// ==== combiner/combinerRegs.sv ====
// Combiner register bank
`timescale 1ns/1ps
`include "combiner_defines.svh"

module combinerRegs import combinerPkg::*; (
    input  logic                   busClk,
    input  logic                   rstN,
    input  logic                   cs,
    input  logic [`REG_ADDR_W-1:0] regAddr,
    input  logic [31:0]            wrData,
    input  logic [3:0]             byteWr,
    output logic [31:0]            rdData,
    input  combStat_t              combStat,
    output combCfg_t               combCfg
);

    logic [`LAG_COEF_W-1:0]  lagCoef;
    logic [`LEAD_COEF_W-1:0] leadCoef;
    logic [31:0]             sweepRate;
    logic [31:0]             locks;
    logic [15:0]             sweepLimit;  // lanes 0 and 1 of the limit address.
    logic [15:0]             options;     // lanes 2 and 3 of the options address.
    logic [31:0]             curWord;
    logic [31:0]             merged;
    lagWord_u                lagNext;
    lagWord_u                lagRd;

    // Replaces only the enabled byte lanes of a word.
    function automatic logic [31:0] mergeLanes(input logic [31:0] oldWord,
                                               input logic [31:0] newWord,
                                               input logic [3:0]  lanes);
        logic [31:0] result;
        result = oldWord;
        for (int i = 0; i < 4; i++) begin
            if (lanes[i]) begin
                result[8*i +: 8] = newWord[8*i +: 8];
            end
        end
        return result;
    endfunction

    always_comb begin
        case (regAddr)
            `COMB_LAG_COEF:    curWord = {{(32-`LAG_COEF_W){1'b0}}, lagCoef};
            `COMB_LEAD_COEF:   curWord = {{(32-`LEAD_COEF_W){1'b0}}, leadCoef};
            `COMB_SWEEP_RATE:  curWord = sweepRate;
            `COMB_LOCKS:       curWord = locks;
            `COMB_SWEEP_LIMIT: curWord = {16'b0, sweepLimit};
            `COMB_OPTIONS:     curWord = {options, 16'b0};
            default:           curWord = '0;
        endcase
    end

    assign merged  = mergeLanes(curWord, wrData, byteWr);
    assign lagNext = merged;  // lane 3 only reaches the two top coefficient bits.

    always_ff @(posedge busClk) begin
        if (!rstN) begin
            lagCoef    <= '0;
            leadCoef   <= '0;
            sweepRate  <= '0;
            locks      <= '0;
            sweepLimit <= '0;
            options    <= '0;
        end else if (cs && |byteWr) begin
            case (regAddr)
                `COMB_LAG_COEF:    lagCoef    <= lagNext.wr.coef;
                `COMB_LEAD_COEF:   leadCoef   <= merged[`LEAD_COEF_W-1:0];  // lane 3 is index.
                `COMB_SWEEP_RATE:  sweepRate  <= merged;
                `COMB_LOCKS:       locks      <= merged;
                `COMB_SWEEP_LIMIT: sweepLimit <= merged[15:0];
                `COMB_OPTIONS:     options    <= merged[31:16];
                default: ;
            endcase
        end
    end

    always_comb begin
        lagRd.rd.ddsMiso      = combStat.ddsMiso;
        lagRd.rd.realLock     = combStat.realLock;
        lagRd.rd.imagLock     = combStat.imagLock;
        lagRd.rd.locked       = combStat.locked;
        lagRd.rd.combinerFlag = combStat.combinerFlag;
        lagRd.rd.agc0GtAgc1   = combStat.agc0GtAgc1;
        lagRd.rd.coef         = lagCoef;
    end

    always_comb begin
        case (regAddr)
            `COMB_LAG_COEF:    rdData = lagRd;
            `COMB_LEAD_COEF:   rdData = {combStat.index, leadCoef};
            `COMB_SWEEP_LIMIT,
            `COMB_OPTIONS:     rdData = {options, sweepLimit};  // both offsets share a word.
            `COMB_SWEEP_RATE:  rdData = sweepRate;
            `COMB_LOCKS:       rdData = locks;
            default:           rdData = '0;
        endcase
    end

    assign combCfg.sweepRate   = sweepRate;
    assign combCfg.sweepLimit  = sweepLimit[7:0];
    assign combCfg.sweepEnable = options[0];

    // A selected offset outside the map must read as zero.
    assert property (@(posedge busClk) disable iff (!rstN)
        cs && (regAddr > `COMB_OPTIONS) |-> rdData == '0);

endmodule

// ==== hdl/busDecoder.sv ====
// Register bus address decoder
`timescale 1ns/1ps
`include "combiner_defines.svh"

module busDecoder import busPkg::*; (
    input  logic                   busClk,
    input  logic                   rstN,
    input  regBusReq_t             busReq,
    output regBusRsp_t             busRsp,
    output logic                   cs,
    output logic [`REG_ADDR_W-1:0] regAddr,
    input  logic [31:0]            bankData
);

    logic baseHit;

    // The top address bits name the bank, the rest is the word offset.
    assign baseHit = busReq.addr[`ADDR_W-1:`REG_ADDR_W] == `COMB_BASE;
    assign cs      = busReq.sel && baseHit;
    assign regAddr = busReq.addr[`REG_ADDR_W-1:0];

    // Unmapped bases and idle cycles read as zero.
    always_comb begin
        if (cs) begin
            busRsp.rdData = bankData;
        end else begin
            busRsp.rdData = '0;
        end
    end

    // The bank is only ever selected by a host strobe.
    assert property (@(posedge busClk) disable iff (!rstN)
        $rose(cs) |-> busReq.sel);

endmodule

// ==== common/combinerPkg.sv ====
// Combiner configuration and status types
package combinerPkg;

`include "combiner_defines.svh"

    // Settings the register bank hands to the sweep engine.
    typedef struct packed {
        logic [31:0] sweepRate;    // phase step added each sweeping cycle.
        logic [7:0]  sweepLimit;   // top byte above this wraps the sweep.
        logic        sweepEnable;  // options bit 0.
    } combCfg_t;

    // Live status returned to the register bank.
    typedef struct packed {
        logic [7:0] index;         // current sweep phase index.
        logic       combinerFlag;  // sweeping and not locked, one cycle late.
        logic       agc0GtAgc1;    // branch 0 stronger than branch 1.
        logic       realLock;
        logic       imagLock;
        logic       locked;
        logic       ddsMiso;
    } combStat_t;

    // The lag word is stored one way and read back another way.
    typedef union packed {
        struct packed {
            logic [31-`LAG_COEF_W:0] unused;  // ignored on writes.
            logic [`LAG_COEF_W-1:0]  coef;
        } wr;
        struct packed {
            logic                   ddsMiso;
            logic                   realLock;
            logic                   imagLock;
            logic                   locked;
            logic                   combinerFlag;
            logic                   agc0GtAgc1;
            logic [`LAG_COEF_W-1:0] coef;
        } rd;
    } lagWord_u;

endpackage

// ==== common/busPkg.sv ====
// Register bus types
package busPkg;

`include "combiner_defines.svh"

    // One host request, valid for a single cycle with no handshake.
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;    // bank base in the top bits, word offset below.
        logic [31:0]        wrData;  // write word, lanes picked by byteWr.
        logic [3:0]         byteWr;  // one enable per byte lane, lane 0 is bits 7:0.
        logic               sel;     // chip-select level from the host.
    } regBusReq_t;

    // Read data returns in the same cycle as the request.
    typedef struct packed {
        logic [31:0] rdData;  // zero when no bank claims the address.
    } regBusRsp_t;

endpackage

// ==== common/combiner_defines.svh ====
// Combiner register map and widths
`ifndef COMBINER_DEFINES_SVH
`define COMBINER_DEFINES_SVH

// Register bus address width; the top two bits pick the bank.
`define ADDR_W 8

// Word offset width inside a bank.
`define REG_ADDR_W 6

// Base bits that select the combiner bank.
`define COMB_BASE 2'b01

// Word offsets of the combiner registers.
`define COMB_LAG_COEF    6'h00
`define COMB_LEAD_COEF   6'h01
`define COMB_SWEEP_RATE  6'h02
`define COMB_LOCKS       6'h03
`define COMB_SWEEP_LIMIT 6'h04
`define COMB_OPTIONS     6'h05

// Stored coefficient widths. The rest of each word carries status on reads.
`define LAG_COEF_W  26
`define LEAD_COEF_W 24

// AGC level width from the two receive branches.
`define AGC_W 16

`endif
